// ==== design/tron_config.svh ====
// Light-cycle arena configuration
`ifndef TRON_CONFIG_SVH
`define TRON_CONFIG_SVH

// Size of the pixel field in cells
`define TRON_FIELD_W 160
`define TRON_FIELD_H 120

// Wall lines that enclose the playing interior
// A head that lands on any of these lines crashes
`define TRON_WALL_LEFT 10
`define TRON_WALL_RIGHT 149
`define TRON_WALL_TOP 17
`define TRON_WALL_BOTTOM 108

// Start cells that both riders return to after every sweep
`define TRON_P1_START_X 25
`define TRON_P1_START_Y 100
`define TRON_P2_START_X 135
`define TRON_P2_START_Y 100

// Clocks between two step ticks of the arena
`define TRON_STEP_CYCLES 32

`endif

// ==== design/tronGeomPkg.sv ====
// Arena geometry types
package tronGeomPkg;

    // Column index on the 160 pixel wide field
    typedef logic [7:0] coordX_t;

    // Row index on the 120 pixel high field
    typedef logic [6:0] coordY_t;

    // Direction of travel of a rider
    // Up decreases y and Right increases x
    typedef enum logic [1:0] {
        Up    = 2'd0,
        Right = 2'd1,
        Down  = 2'd2,
        Left  = 2'd3
    } heading_t;

    // Steering switches of one rider, one bit per direction
    // Bit 3 is left, bit 2 is down, bit 1 is up and bit 0 is right
    typedef logic [3:0] steer_t;

    // One-hot switch patterns that request a turn
    localparam steer_t SteerRight = 4'b0001;
    localparam steer_t SteerUp    = 4'b0010;
    localparam steer_t SteerDown  = 4'b0100;
    localparam steer_t SteerLeft  = 4'b1000;

endpackage

// ==== design/tronPixelPkg.sv ====
// Pixel and score types
package tronPixelPkg;

    // Three bit RGB colour of one pixel write
    // Rider 1 draws in blue, rider 2 in red, and the sweep in black
    typedef enum logic [2:0] {
        Black = 3'b000,
        Blue  = 3'b001,
        Red   = 3'b100
    } pixelColour_t;

    // Two digit decimal score of one rider
    // Each digit holds a value from 0 to 9
    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] ones;
    } bcdScore_t;

endpackage

// ==== design/riderIf.sv ====
// Rider to arena link
`timescale 1ns/1ps

interface riderIf;
    import tronGeomPkg::*;

    // Current head cell of the rider
    coordX_t headX;
    coordY_t headY;

    // One-cycle strobes from the arena
    // Step advances the head, restart sends it back to the start cell
    logic step;
    logic restart;

    // The rider owns its position and follows the arena strobes
    modport lightCycle (output headX, output headY, input step, input restart);

    // The arena reads the head and paces the rider
    modport arena (input headX, input headY, output step, output restart);

endinterface

// ==== design/lightCycle.sv ====
// Single rider heading and position
`timescale 1ns/1ps

module lightCycle #(
    parameter tronGeomPkg::coordX_t START_X = 8'd0,
    parameter tronGeomPkg::coordY_t START_Y = 7'd0
) (
    input  logic                clk,
    input  logic                resetn,
    input  tronGeomPkg::steer_t steer,
    riderIf.lightCycle          rider
);
    import tronGeomPkg::*;

    heading_t heading;
    heading_t nextHeading;

    // Only a single switch that asks for a perpendicular direction turns the rider
    // Reverse requests, idle switches and several switches at once leave it unchanged
    always_comb begin
        nextHeading = heading;
        case (heading)
            Up, Down: begin
                if (steer == SteerRight) begin
                    nextHeading = Right;
                end else if (steer == SteerLeft) begin
                    nextHeading = Left;
                end
            end
            default: begin
                // Travelling horizontally, so only vertical turns are allowed
                if (steer == SteerUp) begin
                    nextHeading = Up;
                end else if (steer == SteerDown) begin
                    nextHeading = Down;
                end
            end
        endcase
    end

    // The heading follows the switches every clock
    // A step therefore moves along the heading held from the previous cycle
    always_ff @(posedge clk) begin
        if (!resetn || rider.restart) begin
            heading     <= Up;
            rider.headX <= START_X;
            rider.headY <= START_Y;
        end else begin
            heading <= nextHeading;
            if (rider.step) begin
                case (heading)
                    Up:      rider.headY <= rider.headY - 7'd1;
                    Down:    rider.headY <= rider.headY + 7'd1;
                    Right:   rider.headX <= rider.headX + 8'd1;
                    default: rider.headX <= rider.headX - 8'd1;
                endcase
            end
        end
    end

endmodule

// ==== design/scoreCounter.sv ====
// Two digit BCD score
`timescale 1ns/1ps

module scoreCounter (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   point,
    output tronPixelPkg::bcdScore_t score
);

    // Each point pulse adds one in decimal
    // The ones digit carries into tens, and tens rolls over from 9 back to 0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            score <= '0;
        end else if (point) begin
            if (score.ones == 4'd9) begin
                score.ones <= 4'd0;
                if (score.tens == 4'd9) begin
                    score.tens <= 4'd0;
                end else begin
                    score.tens <= score.tens + 4'd1;
                end
            end else begin
                score.ones <= score.ones + 4'd1;
            end
        end
    end

endmodule

// ==== design/arenaController.sv ====
// Arena board, crash rules and drawing
`timescale 1ns/1ps
`include "tron_config.svh"

module arenaController (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       run,
    input  logic                       clearBoard,
    riderIf.arena                      rider1,
    riderIf.arena                      rider2,
    output tronGeomPkg::coordX_t       plotX,
    output tronGeomPkg::coordY_t       plotY,
    output tronPixelPkg::pixelColour_t plotColour,
    output logic                       plot,
    output logic                       crashed,
    output logic                       point1,
    output logic                       point2
);
    import tronGeomPkg::*;
    import tronPixelPkg::*;

    typedef enum logic [1:0] {Idle, Check, Plot2, Sweep} arenaState_t;

    localparam int StepW = $clog2(`TRON_STEP_CYCLES);
    localparam logic [StepW-1:0] StepLast = StepW'(`TRON_STEP_CYCLES - 1);

    // Interior corners visited by the clear sweep
    localparam coordX_t SweepXFirst = coordX_t'(`TRON_WALL_LEFT + 1);
    localparam coordX_t SweepXLast  = coordX_t'(`TRON_WALL_RIGHT - 1);
    localparam coordY_t SweepYFirst = coordY_t'(`TRON_WALL_TOP + 1);
    localparam coordY_t SweepYLast  = coordY_t'(`TRON_WALL_BOTTOM - 1);

    arenaState_t state;
    logic [StepW-1:0] stepCount;
    logic sweepPending;
    coordX_t sweepX;
    coordY_t sweepY;
    logic lastCell;
    logic stepPulse;
    logic sameHead;
    logic crash1;
    logic crash2;
    logic anyCrash;

    // One bit per field cell, set once a rider has passed through it
    logic board [`TRON_FIELD_W][`TRON_FIELD_H];

    function automatic logic onWall(input coordX_t x, input coordY_t y);
        return (x == `TRON_WALL_LEFT) || (x == `TRON_WALL_RIGHT) ||
               (y == `TRON_WALL_TOP) || (y == `TRON_WALL_BOTTOM);
    endfunction

    // Crash rules use the fresh heads against the board from before this step
    assign sameHead = (rider1.headX == rider2.headX) && (rider1.headY == rider2.headY);
    assign crash1   = onWall(rider1.headX, rider1.headY) ||
                      board[rider1.headX][rider1.headY] || sameHead;
    assign crash2   = onWall(rider2.headX, rider2.headY) ||
                      board[rider2.headX][rider2.headY] || sameHead;
    assign anyCrash = crash1 || crash2;

    // A crash credits the other rider, both when they collide together
    assign point1 = (state == Check) && crash2;
    assign point2 = (state == Check) && crash1;

    // Steps are only issued from Idle, and a pending clear wins over a step
    assign stepPulse = run && (state == Idle) && !clearBoard && !sweepPending &&
                       (stepCount == StepLast);
    assign lastCell  = (state == Sweep) && (sweepX == SweepXLast) && (sweepY == SweepYLast);

    assign rider1.step    = stepPulse;
    assign rider2.step    = stepPulse;
    assign rider1.restart = lastCell;
    assign rider2.restart = lastCell;

    // Pixel stream, rider 1 in the check cycle, rider 2 in the cycle after it
    always_comb begin
        plot       = 1'b0;
        plotX      = sweepX;
        plotY      = sweepY;
        plotColour = Black;
        case (state)
            Check: begin
                plot       = !anyCrash;
                plotX      = rider1.headX;
                plotY      = rider1.headY;
                plotColour = Blue;
            end
            Plot2: begin
                plot       = 1'b1;
                plotX      = rider2.headX;
                plotY      = rider2.headY;
                plotColour = Red;
            end
            Sweep: plot = 1'b1;
            default: plot = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= Idle;
            sweepPending <= 1'b1;
            crashed      <= 1'b0;
            stepCount    <= '0;
            sweepX       <= SweepXFirst;
            sweepY       <= SweepYFirst;
        end else begin
            // Step timer halts with run low and starts over after every sweep
            if (state == Sweep) begin
                stepCount <= '0;
            end else if (run) begin
                stepCount <= (stepCount == StepLast) ? '0 : stepCount + 1'b1;
            end

            case (state)
                Idle: begin
                    if (clearBoard || sweepPending) begin
                        state        <= Sweep;
                        sweepPending <= 1'b0;
                    end else if (stepPulse) begin
                        state <= Check;
                    end
                end
                Check: begin
                    if (anyCrash) begin
                        state   <= Sweep;
                        crashed <= 1'b1;
                    end else begin
                        state <= Plot2;
                    end
                end
                Plot2: state <= Idle;
                default: begin
                    if (lastCell) begin
                        state   <= Idle;
                        crashed <= 1'b0;
                    end
                end
            endcase

            // Sweep walks down each column before moving one column right
            if (state != Sweep) begin
                sweepX <= SweepXFirst;
                sweepY <= SweepYFirst;
            end else if (sweepY == SweepYLast) begin
                sweepY <= SweepYFirst;
                sweepX <= sweepX + 8'd1;
            end else begin
                sweepY <= sweepY + 7'd1;
            end
        end
    end

    // Trails are marked after a clean step and wiped cell by cell during a sweep
    always_ff @(posedge clk) begin
        if (state == Sweep) begin
            board[sweepX][sweepY] <= 1'b0;
        end else if ((state == Check) && !anyCrash) begin
            board[rider1.headX][rider1.headY] <= 1'b1;
            board[rider2.headX][rider2.headY] <= 1'b1;
        end
    end

endmodule

// ==== design/tronGame.sv ====
// Two rider light-cycle game
`timescale 1ns/1ps
`include "tron_config.svh"

module tronGame (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       run,
    input  logic                       clearBoard,
    input  tronGeomPkg::steer_t        steer1,
    input  tronGeomPkg::steer_t        steer2,
    output tronGeomPkg::coordX_t       plotX,
    output tronGeomPkg::coordY_t       plotY,
    output tronPixelPkg::pixelColour_t plotColour,
    output logic                       plot,
    output logic                       crashed,
    output tronPixelPkg::bcdScore_t    score1,
    output tronPixelPkg::bcdScore_t    score2
);

    logic point1;
    logic point2;

    // One link per rider between its cycle and the arena
    riderIf r1If ();
    riderIf r2If ();

    lightCycle #(
        .START_X(8'(`TRON_P1_START_X)),
        .START_Y(7'(`TRON_P1_START_Y))
    ) rider1 (
        .clk   (clk),
        .resetn(resetn),
        .steer (steer1),
        .rider (r1If)
    );

    lightCycle #(
        .START_X(8'(`TRON_P2_START_X)),
        .START_Y(7'(`TRON_P2_START_Y))
    ) rider2 (
        .clk   (clk),
        .resetn(resetn),
        .steer (steer2),
        .rider (r2If)
    );

    arenaController arena (
        .clk       (clk),
        .resetn    (resetn),
        .run       (run),
        .clearBoard(clearBoard),
        .rider1    (r1If),
        .rider2    (r2If),
        .plotX     (plotX),
        .plotY     (plotY),
        .plotColour(plotColour),
        .plot      (plot),
        .crashed   (crashed),
        .point1    (point1),
        .point2    (point2)
    );

    // Point1 rewards rider 1 when rider 2 crashes, and point2 the reverse
    scoreCounter score1Counter (
        .clk   (clk),
        .resetn(resetn),
        .point (point1),
        .score (score1)
    );

    scoreCounter score2Counter (
        .clk   (clk),
        .resetn(resetn),
        .point (point2),
        .score (score2)
    );

endmodule

// ==== tests/tronGame_assertions.sv ====
// Arena controller protocol checks
`timescale 1ns/1ps
`include "tron_config.svh"

module tronGame_assertions (
    input logic       clk,
    input logic       resetn,
    input logic       step,
    input logic       restart,
    input logic       plot,
    input logic       crashed,
    input logic [7:0] plotX,
    input logic [6:0] plotY
);

    localparam int CountW = $clog2(`TRON_STEP_CYCLES) + 1;

    // Cycles since the last restart, held once a full step period has passed
    logic [CountW-1:0] sinceRestart;

    always_ff @(posedge clk) begin
        if (!resetn || restart) begin
            sinceRestart <= '0;
        end else if (sinceRestart != '1) begin
            sinceRestart <= sinceRestart + 1'b1;
        end
    end

    // A restart sends both riders home and the step timer starts over
    // No step may come with it or within one step period after it
    stepRestartApart: assert property (@(posedge clk) disable iff (!resetn)
        step |-> !restart && (sinceRestart >= CountW'(`TRON_STEP_CYCLES - 1)))
        else $error("Step pulsed with a restart or too soon after it");

    // Every pixel write lands strictly inside the wall lines
    plotInterior: assert property (@(posedge clk) disable iff (!resetn)
        plot |-> (plotX > `TRON_WALL_LEFT) && (plotX < `TRON_WALL_RIGHT) &&
                 (plotY > `TRON_WALL_TOP) && (plotY < `TRON_WALL_BOTTOM))
        else $error("Pixel write outside the interior");

    // Crashed holds until the sweep hands out its restart
    crashedHolds: assert property (@(posedge clk) disable iff (!resetn)
        (crashed && !restart) |=> crashed)
        else $error("Crashed fell before restart");

endmodule

bind arenaController tronGame_assertions arenaChecks (
    .clk    (clk),
    .resetn (resetn),
    .step   (stepPulse),
    .restart(lastCell),
    .plot   (plot),
    .crashed(crashed),
    .plotX  (plotX),
    .plotY  (plotY)
);

// ==== tests/tronGame_tb.sv ====
// Light-cycle game testbench
`timescale 1ns/1ps
`include "tron_config.svh"

module tronGame_tb;
    import tronGeomPkg::*;
    import tronPixelPkg::*;

    localparam int SweepRows  = `TRON_WALL_BOTTOM - `TRON_WALL_TOP - 1;
    localparam int SweepCells = (`TRON_WALL_RIGHT - `TRON_WALL_LEFT - 1) * SweepRows;
    // Watchdog budget from the sweeps and steps the tests can take, doubled
    localparam longint MaxSweeps = 20;
    localparam longint MaxSteps  = 2500;
    localparam longint TimeoutCycles = 2 * (MaxSweeps * SweepCells + MaxSteps * `TRON_STEP_CYCLES);

    logic clk;
    logic resetn;
    logic run;
    logic clearBoard;
    steer_t steer1;
    steer_t steer2;
    coordX_t plotX;
    coordY_t plotY;
    pixelColour_t plotColour;
    logic plot;
    logic crashed;
    bcdScore_t score1;
    bcdScore_t score2;

    // Reference model state
    heading_t h1, h1One, h1Two, h2, h2One, h2Two;
    int head1X, head1Y, head2X, head2Y;
    bit board [`TRON_FIELD_W][`TRON_FIELD_H];
    bcdScore_t expScore1, expScore2;
    int sweepCnt, sweepsDone, blueCount, plotCount, crashCount, stepsSinceRestart;
    int firstBlueX, firstBlueY, firstRedX, firstRedY;
    bit lastCrash1, lastCrash2, crashedPrev;
    int errors;
    string testName;
    logic [31:0] rndState;

    tronGame tronGame_inst (
        .clk(clk), .resetn(resetn), .run(run), .clearBoard(clearBoard),
        .steer1(steer1), .steer2(steer2), .plotX(plotX), .plotY(plotY),
        .plotColour(plotColour), .plot(plot), .crashed(crashed),
        .score1(score1), .score2(score2)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Only one switch at right angles to the travel turns the rider
    function automatic heading_t turnRef(input heading_t h, input steer_t s);
        heading_t n;
        n = h;
        if ((h == Up || h == Down) && s == 4'b0001) n = Right;
        if ((h == Up || h == Down) && s == 4'b1000) n = Left;
        if ((h == Left || h == Right) && s == 4'b0010) n = Up;
        if ((h == Left || h == Right) && s == 4'b0100) n = Down;
        return n;
    endfunction

    // Next head cell, x in the upper half and y in the lower half
    function automatic logic [31:0] moveRef(input int x, input int y, input heading_t h);
        int nx;
        int ny;
        nx = x;
        ny = y;
        case (h)
            Up:    ny = y - 1;
            Down:  ny = y + 1;
            Right: nx = x + 1;
            default: nx = x - 1;
        endcase
        return {nx[15:0], ny[15:0]};
    endfunction

    function automatic bit crashRef(input int x, input int y, input int ox, input int oy);
        bit wall;
        wall = (x == `TRON_WALL_LEFT) || (x == `TRON_WALL_RIGHT) ||
               (y == `TRON_WALL_TOP) || (y == `TRON_WALL_BOTTOM);
        return wall || board[x][y] || (x == ox && y == oy);
    endfunction

    function automatic bcdScore_t bcdInc(input bcdScore_t s);
        bcdScore_t r;
        r = s;
        if (s.ones == 4'd9) begin
            r.ones = 4'd0;
            r.tens = (s.tens == 4'd9) ? 4'd0 : s.tens + 4'd1;
        end else begin
            r.ones = s.ones + 4'd1;
        end
        return r;
    endfunction

    task automatic failValue(input string what, input int expected, input int actual);
        errors++;
        $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
    endtask

    task automatic clearModel();
        foreach (board[x, y]) board[x][y] = 1'b0;
        head1X = `TRON_P1_START_X;
        head1Y = `TRON_P1_START_Y;
        head2X = `TRON_P2_START_X;
        head2Y = `TRON_P2_START_Y;
        sweepCnt = 0;
        stepsSinceRestart = 0;
    endtask

    // Comparing process, samples outputs on the rising edge
    always @(posedge clk) begin
        logic [31:0] n1;
        logic [31:0] n2;
        bit c1;
        bit c2;
        bit restartNow;
        restartNow = 1'b0;
        if (!resetn) begin
            h1 = Up;
            h1One = Up;
            h1Two = Up;
            h2 = Up;
            h2One = Up;
            h2Two = Up;
            clearModel();
            expScore1 = '0;
            expScore2 = '0;
            crashedPrev = 1'b0;
        end else begin
            if (plot) plotCount++;
            if (plot && plotColour == Black) begin
                assert (plotX == 11 + sweepCnt / SweepRows)
                    else failValue("sweep x", 11 + sweepCnt / SweepRows, plotX);
                assert (plotY == 18 + sweepCnt % SweepRows)
                    else failValue("sweep y", 18 + sweepCnt % SweepRows, plotY);
                sweepCnt++;
                if (sweepCnt == SweepCells) begin
                    restartNow = 1'b1;
                    sweepsDone++;
                end
            end else if (plot && plotColour == Blue) begin
                n1 = moveRef(head1X, head1Y, h1One);
                n2 = moveRef(head2X, head2Y, h2One);
                c1 = crashRef(n1[31:16], n1[15:0], n2[31:16], n2[15:0]);
                c2 = crashRef(n2[31:16], n2[15:0], n1[31:16], n1[15:0]);
                assert (!(c1 || c2)) else begin
                    errors++;
                    $display("Error in %s: trail plotted where the model predicts a crash",
                             testName);
                end
                assert (plotX == n1[31:16]) else failValue("blue x", n1[31:16], plotX);
                assert (plotY == n1[15:0]) else failValue("blue y", n1[15:0], plotY);
                head1X = n1[31:16];
                head1Y = n1[15:0];
                head2X = n2[31:16];
                head2Y = n2[15:0];
                board[head1X][head1Y] = 1'b1;
                board[head2X][head2Y] = 1'b1;
                if (stepsSinceRestart == 0) begin
                    firstBlueX = plotX;
                    firstBlueY = plotY;
                end
                stepsSinceRestart++;
                blueCount++;
            end else if (plot && plotColour == Red) begin
                assert (plotX == head2X) else failValue("red x", head2X, plotX);
                assert (plotY == head2Y) else failValue("red y", head2Y, plotY);
                if (stepsSinceRestart == 1) begin
                    firstRedX = plotX;
                    firstRedY = plotY;
                end
            end else if (plot) begin
                errors++;
                $display("Error in %s: pixel write with an unknown colour", testName);
            end

            // A crash shows one edge after its check cycle, so the step used h?Two
            if (crashed && !crashedPrev) begin
                n1 = moveRef(head1X, head1Y, h1Two);
                n2 = moveRef(head2X, head2Y, h2Two);
                c1 = crashRef(n1[31:16], n1[15:0], n2[31:16], n2[15:0]);
                c2 = crashRef(n2[31:16], n2[15:0], n1[31:16], n1[15:0]);
                assert (c1 || c2) else begin
                    errors++;
                    $display("Error in %s: crash reported but the model sees none", testName);
                end
                if (c2) expScore1 = bcdInc(expScore1);
                if (c1) expScore2 = bcdInc(expScore2);
                lastCrash1 = c1;
                lastCrash2 = c2;
                crashCount++;
            end
            crashedPrev = crashed;
            assert (score1 == expScore1) else failValue("score1", expScore1, score1);
            assert (score2 == expScore2) else failValue("score2", expScore2, score2);

            h1Two = h1One;
            h1One = h1;
            h2Two = h2One;
            h2One = h2;
            h1 = restartNow ? Up : turnRef(h1, steer1);
            h2 = restartNow ? Up : turnRef(h2, steer2);
            if (restartNow) clearModel();
        end
    end

    task automatic waitSweeps(input int target);
        while (sweepsDone < target) @(negedge clk);
    endtask

    task automatic waitBlue(input int n);
        int target;
        target = blueCount + n;
        while (blueCount < target && !crashed) @(negedge clk);
    endtask

    // Waits for the next crash and for the sweep that follows it
    task automatic waitCrash();
        int target;
        target = crashCount + 1;
        while (crashCount < target) @(negedge clk);
        while (crashed) @(negedge clk);
    endtask

    // Stops the riders and clears the board so that both restart at their start cells
    task automatic restartArena();
        run = 1'b0;
        steer1 = '0;
        steer2 = '0;
        repeat (4) @(negedge clk);
        while (crashed) @(negedge clk);
        repeat (2) @(negedge clk);
        clearBoard = 1'b1;
        @(negedge clk);
        clearBoard = 1'b0;
        waitSweeps(sweepsDone + 1);
    endtask

    task automatic checkStartCells();
        assert (firstBlueX == `TRON_P1_START_X)
            else failValue("first blue x", `TRON_P1_START_X, firstBlueX);
        assert (firstBlueY == `TRON_P1_START_Y - 1)
            else failValue("first blue y", `TRON_P1_START_Y - 1, firstBlueY);
        assert (firstRedX == `TRON_P2_START_X)
            else failValue("first red x", `TRON_P2_START_X, firstRedX);
        assert (firstRedY == `TRON_P2_START_Y - 1)
            else failValue("first red y", `TRON_P2_START_Y - 1, firstRedY);
    endtask

    // Stimulus, driven on the falling edge
    initial begin
        bcdScore_t s1;
        bcdScore_t s2;
        int p;
        int target;
        errors = 0;
        sweepsDone = 0;
        blueCount = 0;
        plotCount = 0;
        crashCount = 0;
        rndState = 32'h5fd4;
        resetn = 1'b0;
        run = 1'b0;
        clearBoard = 1'b0;
        steer1 = '0;
        steer2 = '0;
        testName = "reset";
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        waitSweeps(1);
        assert (!crashed) else failValue("crashed", 0, crashed);
        assert (score1 == 8'h00 && score2 == 8'h00) else failValue("scores", 0, {score1, score2});

        testName = "straight run";
        run = 1'b1;
        waitBlue(6);
        @(negedge clk);
        @(negedge clk);
        checkStartCells();

        testName = "random steering";
        target = blueCount + 40;
        while (blueCount < target && !crashed) begin
            @(negedge clk);
            rndState = xorshift(rndState);
            steer1 = rndState[3:0];
            steer2 = rndState[11:8];
        end
        restartArena();

        testName = "wall crash";
        s1 = score1;
        s2 = score2;
        run = 1'b1;
        waitCrash();
        assert (lastCrash1 && lastCrash2) else failValue("both crash", 1, lastCrash1 && lastCrash2);
        assert (score1 == bcdInc(s1)) else failValue("score1", bcdInc(s1), score1);
        assert (score2 == bcdInc(s2)) else failValue("score2", bcdInc(s2), score2);
        waitBlue(1);
        repeat (3) @(negedge clk);
        checkStartCells();
        restartArena();

        testName = "trail crash";
        s1 = score1;
        s2 = score2;
        run = 1'b1;
        waitBlue(3);
        steer1 = SteerRight;
        waitBlue(1);
        steer1 = SteerDown;
        waitBlue(1);
        steer1 = SteerLeft;
        waitCrash();
        steer1 = '0;
        assert (lastCrash1 && !lastCrash2) else failValue("rider 1 crash", 1, lastCrash1);
        assert (score1 == s1) else failValue("score1", s1, score1);
        assert (score2 == bcdInc(s2)) else failValue("score2", bcdInc(s2), score2);
        restartArena();

        testName = "head-on crash";
        steer1 = SteerRight;
        steer2 = SteerLeft;
        run = 1'b1;
        waitCrash();
        assert (lastCrash1 && lastCrash2) else failValue("both crash", 1, lastCrash1 && lastCrash2);
        restartArena();

        // Eight wall crashes carry both scores past 09
        testName = "score carry";
        s1 = score1;
        s2 = score2;
        run = 1'b1;
        repeat (8) begin
            waitCrash();
            s1 = bcdInc(s1);
            s2 = bcdInc(s2);
        end
        assert (score1 == s1) else failValue("score1", s1, score1);
        assert (score2 == s2) else failValue("score2", s2, score2);
        restartArena();

        testName = "run low and clear";
        p = plotCount;
        repeat (200) @(negedge clk);
        assert (plotCount == p) else failValue("plots", p, plotCount);
        s1 = score1;
        s2 = score2;
        clearBoard = 1'b1;
        @(negedge clk);
        clearBoard = 1'b0;
        waitSweeps(sweepsDone + 1);
        assert (score1 == s1 && score2 == s2) else failValue("scores", {s1, s2}, {score1, score2});

        repeat (4) @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TimeoutCycles * 20);
        $display("Timeout: the tests did not finish in %0d cycles, errors so far %0d",
                 TimeoutCycles, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/tronGeomPkg.sv
design/tronPixelPkg.sv
design/riderIf.sv
design/lightCycle.sv
design/scoreCounter.sv
design/arenaController.sv
design/tronGame.sv
tests/tronGame_assertions.sv
tests/tronGame_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the light-cycle testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -Idesign \
    --top-module tronGame_tb -f project.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "All checks passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
